// File: Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module game_top_tb \
		-f filelist.f -Mdir obj_dir -o game_top_tb

run: compile
	./obj_dir/game_top_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Everything OK" $(LOG)
	! grep -q "Something failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/collision_detector.sv
`timescale 1ns/10ps

module collision_detector
	import geometry_pkg::*;
	import defines::*;
#(
	parameter int N_OBSTACLES = 3
) (
	input	logic				clk,
	input	logic				resetN,
	input	rect_t				smiley,
	input	rect_t [N_OBSTACLES-1:0]	obstacles,
	input	logic [N_OBSTACLES-1:0]		obst_good,
	output	collision_t			collision,
	output	logic [N_OBSTACLES-1:0]		hit
);

	localparam coord_t Y_BOTTOM = SCREEN_H - SMILEY_SIZE;

	logic [N_OBSTACLES-1:0] overlap;
	logic [N_OBSTACLES-1:0] overlap_d;
	logic [N_OBSTACLES-1:0] obst_new;
	logic border;
	logic border_d;
	logic border_new;

	// bounding box tests
	always_comb begin
		for (int k = 0; k < N_OBSTACLES; k++) begin
			overlap[k] = smiley.visible && obstacles[k].visible &&
				(smiley.x < obstacles[k].x + OBST_W) &&
				(obstacles[k].x < smiley.x + SMILEY_SIZE) &&
				(smiley.y < obstacles[k].y + OBST_H) &&
				(obstacles[k].y < smiley.y + SMILEY_SIZE);
		end
	end

	assign border = smiley.visible && (smiley.y >= Y_BOTTOM);

	// new contacts only; border wins over obstacles
	assign border_new = border && !border_d;
	assign obst_new = overlap & ~overlap_d & {N_OBSTACLES{~border_new}};

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			overlap_d <= '0;
			border_d <= 1'b0;
			collision <= '0;
			hit <= '0;
		end else begin
			overlap_d <= overlap;
			border_d <= border;
			collision.border_bottom <= border_new;
			collision.obstacle <= |obst_new;
			collision.obstacle_good <= |(obst_new & obst_good);
			collision.obstacle_bad <= |(obst_new & ~obst_good);
			hit <= obst_new;	// back to the field for removal
		end
	end

endmodule

// File: design/defines.sv
package defines;

	// game rules
	localparam logic [3:0] LIFE_INIT = 4'd3;
	localparam logic [3:0] SCORE_PER_LEVEL = 4'd2;	// good hits per level

	// one-cycle collision strobes
	typedef struct packed {
		logic border_bottom;
		logic obstacle;
		logic obstacle_good;
		logic obstacle_bad;
	} collision_t;

	// controller outputs
	typedef struct packed {
		logic pause;
		logic reset_level;
		logic reset_level_pulse;	// rising edge of reset_level
		logic [3:0] score;
		logic [3:0] level;
		logic [3:0] life;
	} game_status_t;

endpackage

// File: design/game_controller.sv
`timescale 1ns/10ps

module game_controller
	import defines::*;
(
	input	logic		clk,
	input	logic		resetN,
	input	logic		key_start,
	input	collision_t	collision,
	output	game_status_t	status
);

	typedef enum logic [1:0] {
		S_INIT,
		S_WAIT,
		S_PLAY,
		S_OVER
	} state_t;

	state_t state_q, state_n;

	logic [3:0] score_q, score_n;
	logic [3:0] level_q, level_n;
	logic [3:0] life_q, life_n;
	logic pause;
	logic reset_level;
	logic reset_level_d;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state_q <= S_INIT;
			score_q <= 4'd0;
			level_q <= 4'd0;
			life_q <= LIFE_INIT;
			reset_level_d <= 1'b0;
		end else begin
			state_q <= state_n;
			score_q <= score_n;
			level_q <= level_n;
			life_q <= life_n;
			reset_level_d <= reset_level;
		end
	end

	always_comb begin
		state_n = state_q;
		score_n = score_q;
		level_n = level_q;
		life_n = life_q;
		pause = 1'b1;
		reset_level = 1'b0;

		case (state_q)
			S_INIT: begin
				state_n = S_WAIT;
			end

			S_WAIT: begin
				score_n = 4'd0;
				reset_level = 1'b1;
				if (key_start)
					state_n = S_PLAY;
			end

			S_PLAY: begin
				pause = 1'b0;
				if (collision.border_bottom) begin
					life_n = life_q - 4'd1;
					if (life_n == 4'd0)
						state_n = S_OVER;
					else
						state_n = S_WAIT;	// retry the level
				end else if (collision.obstacle && collision.obstacle_good) begin
					if (score_q + 4'd1 == SCORE_PER_LEVEL) begin
						level_n = level_q + 4'd1;	// level done, score cleared in wait
						state_n = S_WAIT;
					end else begin
						score_n = score_q + 4'd1;
					end
				end
				// bad obstacles only vanish
			end

			S_OVER: begin
				score_n = 4'd0;
				level_n = 4'd0;
				life_n = LIFE_INIT;
				reset_level = 1'b1;
				if (key_start)
					state_n = S_PLAY;
			end

			default: state_n = S_INIT;
		endcase
	end

	assign status.pause = pause;
	assign status.reset_level = reset_level;
	assign status.reset_level_pulse = reset_level && !reset_level_d;
	assign status.score = score_q;
	assign status.level = level_q;
	assign status.life = life_q;

endmodule

// File: design/game_top.sv
`timescale 1ns/10ps

module game_top
	import geometry_pkg::*;
	import defines::*;
#(
	parameter int N_OBSTACLES = 3
) (
	input	logic		clk,
	input	logic		resetN,
	input	logic		tick,
	input	logic		key_start,
	input	logic		key_left,
	input	logic		key_right,
	output	game_status_t	status
);

	rect_t smiley;
	rect_t [N_OBSTACLES-1:0] obstacles;
	logic [N_OBSTACLES-1:0] obst_good;
	logic [N_OBSTACLES-1:0] hit;
	collision_t collision;

	smiley_motion smiley_motion_i (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.pause(status.pause),
		.reset_level_pulse(status.reset_level_pulse),
		.key_left(key_left),
		.key_right(key_right),
		.level(status.level),	// fall speed
		.smiley(smiley)
	);

	obstacle_field #(.N_OBSTACLES(N_OBSTACLES)) obstacle_field_i (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.pause(status.pause),
		.reset_level_pulse(status.reset_level_pulse),
		.hit(hit),
		.obstacles(obstacles),
		.obst_good(obst_good)
	);

	collision_detector #(.N_OBSTACLES(N_OBSTACLES)) collision_detector_i (
		.clk(clk),
		.resetN(resetN),
		.smiley(smiley),
		.obstacles(obstacles),
		.obst_good(obst_good),
		.collision(collision),
		.hit(hit)
	);

	game_controller game_controller_i (
		.clk(clk),
		.resetN(resetN),
		.key_start(key_start),
		.collision(collision),
		.status(status)
	);

endmodule

// File: design/geometry_pkg.sv
package geometry_pkg;

	typedef logic [7:0] coord_t;

	// screen in object units
	localparam coord_t SCREEN_W = 8'd64;
	localparam coord_t SCREEN_H = 8'd48;

	// object sizes
	localparam coord_t SMILEY_SIZE = 8'd4;
	localparam coord_t OBST_W = 8'd8;
	localparam coord_t OBST_H = 8'd2;

	// start placement
	localparam coord_t SMILEY_START_X = 8'd30;
	localparam coord_t SMILEY_START_Y = 8'd0;
	localparam coord_t OBST_ROW_SPACING = 8'd12;	// obstacle i in row (i+1)*spacing

	// top left corner plus visibility
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic visible;
	} rect_t;

endpackage

// File: design/obstacle_field.sv
`timescale 1ns/10ps

module obstacle_field
	import geometry_pkg::*;
#(
	parameter int N_OBSTACLES = 3
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				tick,
	input	logic				pause,
	input	logic				reset_level_pulse,
	input	logic [N_OBSTACLES-1:0]		hit,
	output	rect_t [N_OBSTACLES-1:0]	obstacles,
	output	logic [N_OBSTACLES-1:0]		obst_good
);

	localparam int START_STEP = 16;	// horizontal offset between obstacles

	logic active;

	assign active = tick && !pause;

	genvar i;
	generate
		for (i = 0; i < N_OBSTACLES; i++) begin : g_obst
			localparam coord_t X_START = coord_t'(START_STEP * i);
			localparam coord_t Y_ROW = coord_t'((i + 1) * OBST_ROW_SPACING);

			coord_t x_q;
			logic visible_q;

			always_ff @(posedge clk or negedge resetN) begin
				if (!resetN) begin
					x_q <= X_START;
					visible_q <= 1'b1;
				end else if (reset_level_pulse) begin
					x_q <= X_START;	// fresh field per level
					visible_q <= 1'b1;
				end else begin
					if (active) begin
						if (x_q == SCREEN_W - 8'd1)
							x_q <= 8'd0;	// wrap to left edge
						else
							x_q <= x_q + 8'd1;
					end
					if (hit[i])
						visible_q <= 1'b0;	// removed on contact
				end
			end

			assign obstacles[i].x = x_q;
			assign obstacles[i].y = Y_ROW;
			assign obstacles[i].visible = visible_q;

			// even good, odd bad
			assign obst_good[i] = ((i % 2) == 0);
		end
	endgenerate

endmodule

// File: design/smiley_motion.sv
`timescale 1ns/10ps

module smiley_motion
	import geometry_pkg::*;
(
	input	logic		clk,
	input	logic		resetN,
	input	logic		tick,
	input	logic		pause,
	input	logic		reset_level_pulse,
	input	logic		key_left,
	input	logic		key_right,
	input	logic [3:0]	level,
	output	rect_t		smiley
);

	localparam coord_t Y_BOTTOM = SCREEN_H - SMILEY_SIZE;	// resting row at the border
	localparam coord_t X_MAX = SCREEN_W - SMILEY_SIZE;

	coord_t x_q;
	coord_t y_q;
	coord_t x_step;
	coord_t y_step;
	logic active;

	assign active = tick && !pause;

	// next position for one frame
	always_comb begin
		y_step = y_q + coord_t'(level) + 8'd1;	// faster fall on higher levels
		if (y_step > Y_BOTTOM)
			y_step = Y_BOTTOM;

		x_step = x_q;
		if (key_left && !key_right && (x_q != 8'd0))
			x_step = x_q - 8'd1;
		else if (key_right && !key_left && (x_q < X_MAX))
			x_step = x_q + 8'd1;	// both keys held cancel out
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			x_q <= SMILEY_START_X;
			y_q <= SMILEY_START_Y;
		end else if (reset_level_pulse) begin
			x_q <= SMILEY_START_X;
			y_q <= SMILEY_START_Y;
		end else if (active) begin
			x_q <= x_step;
			y_q <= y_step;
		end
	end

	assign smiley.x = x_q;
	assign smiley.y = y_q;
	assign smiley.visible = 1'b1;	// always drawn

endmodule

// File: filelist.f
design/defines.sv
design/geometry_pkg.sv
design/smiley_motion.sv
design/obstacle_field.sv
design/collision_detector.sv
design/game_controller.sv
design/game_top.sv
tb/game_top_assertions.sv
tb/game_top_tb.sv

// File: tb/game_top_assertions.sv
`timescale 1ns/10ps

module game_top_assertions
	import defines::*;
(
	input	logic		clk,
	input	logic		resetN,
	input	game_status_t	status
);

	// a pulse marks one edge only
	pulse_single: assert property (@(posedge clk) disable iff (!resetN)
		status.reset_level_pulse |=> !status.reset_level_pulse)
		else $error("reset_level_pulse high for two cycles");

	// play needs a life left
	life_in_play: assert property (@(posedge clk) disable iff (!resetN)
		!status.pause |-> (status.life != 4'd0))
		else $error("life is 0 during play");

	score_range: assert property (@(posedge clk) disable iff (!resetN)
		status.score < SCORE_PER_LEVEL)
		else $error("score reached the level limit");

endmodule

bind game_controller game_top_assertions game_top_assertions_i (
	.clk(clk),
	.resetN(resetN),
	.status(status)
);

// File: tb/game_top_tb.sv
`timescale 1ns/10ps

module game_top_tb
	import geometry_pkg::*;
	import defines::*;
;

	localparam int N_OBSTACLES = 3;
	localparam int CLK_PERIOD = 40;

	// ticks per drop from the fall and scroll rules
	localparam int BOTTOM_L0 = SCREEN_H - SMILEY_SIZE;	// 1 row per tick
	localparam int BOTTOM_L1 = (SCREEN_H - SMILEY_SIZE) / 2;	// 2 rows per tick
	localparam int GOOD0_TICK = 12;	// left held, first overlap with obstacle 0
	localparam int GOOD2_TICK = 33;	// left held, x clamped at 0, obstacle 2 wrapped
	localparam int BAD1_TICK = 11;	// level 1, no keys, obstacle 1 passes x 27
	localparam int PAUSED_TICKS = 3;
	localparam int TOTAL_TICKS = PAUSED_TICKS + BOTTOM_L0 + GOOD2_TICK + 2 * BOTTOM_L1;
	localparam int WATCHDOG_CYCLES = TOTAL_TICKS * 4 + 200;

	logic clk;
	logic resetN;
	logic tick;
	logic key_start;
	logic key_left;
	logic key_right;
	game_status_t status;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int pulse_count = 0;

	game_top #(.N_OBSTACLES(N_OBSTACLES)) dut_i (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.key_start(key_start),
		.key_left(key_left),
		.key_right(key_right),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk) begin
		if (resetN && status.reset_level_pulse)
			pulse_count++;	// one per level restart
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	function automatic game_status_t expected_status(logic p, logic rl, logic [3:0] score,
			logic [3:0] level, logic [3:0] life);
		game_status_t s;
		s.pause = p;
		s.reset_level = rl;
		s.reset_level_pulse = 1'b0;	// checked between pulses
		s.score = score;
		s.level = level;
		s.life = life;
		return s;
	endfunction

	function automatic string status_text(game_status_t s);
		return $sformatf("p=%b rl=%b rlp=%b s=%0d lv=%0d lf=%0d", s.pause, s.reset_level,
			s.reset_level_pulse, s.score, s.level, s.life);
	endfunction

	task automatic check_status(game_status_t got, game_status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: status got %s, expected %s", $time,
				status_text(got), status_text(exp));
		end
	endtask

	task automatic check_counter(logic [3:0] got, logic [3:0] exp, string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic settle(int n);
		repeat (n) @(posedge clk);
		@(negedge clk);
	endtask

	// tick edge, strobe edge, counter edge
	task automatic do_tick();
		@(posedge clk) tick <= 1'b1;
		@(posedge clk) tick <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic run_ticks(int n);
		repeat (n) do_tick();
	endtask

	task automatic press_start();
		@(posedge clk) key_start <= 1'b1;
		@(posedge clk) key_start <= 1'b0;
		settle(0);
	endtask

	task automatic finish_test(string name, int err_before);
		tests++;
		$display("%-14s %s", name, (errors == err_before) ? "pass" : "FAIL");
	endtask

	task automatic test_reset();
		int e;
		e = errors;
		settle(3);
		check_status(status, expected_status(1'b1, 1'b1, 4'd0, 4'd0, LIFE_INIT));
		check_counter(4'(pulse_count), 4'd1, "reset_level_pulse count");
		finish_test("reset", e);
	endtask

	task automatic test_start();
		int e;
		e = errors;
		@(posedge clk) key_left <= 1'b1;
		run_ticks(PAUSED_TICKS);	// ignored while paused
		@(posedge clk) key_left <= 1'b0;
		settle(0);
		check_status(status, expected_status(1'b1, 1'b1, 4'd0, 4'd0, LIFE_INIT));
		press_start();
		check_status(status, expected_status(1'b0, 1'b0, 4'd0, 4'd0, LIFE_INIT));
		finish_test("start", e);
	endtask

	task automatic test_bottom();
		int e;
		int p;
		e = errors;
		p = pulse_count;
		@(posedge clk) key_right <= 1'b1;	// right edge stays clear of obstacles
		run_ticks(BOTTOM_L0 - 1);	// one row above the border
		settle(0);
		check_status(status, expected_status(1'b0, 1'b0, 4'd0, 4'd0, LIFE_INIT));
		run_ticks(1);
		@(posedge clk) key_right <= 1'b0;
		settle(1);
		check_status(status, expected_status(1'b1, 1'b1, 4'd0, 4'd0, LIFE_INIT - 4'd1));
		check_counter(4'(pulse_count - p), 4'd1, "reset_level_pulse count");
		press_start();
		finish_test("bottom", e);
	endtask

	task automatic test_good_hits();
		int e;
		e = errors;
		@(posedge clk) key_left <= 1'b1;
		run_ticks(GOOD0_TICK);
		settle(0);
		check_counter(status.score, 4'd1, "score");
		run_ticks(GOOD2_TICK - GOOD0_TICK);
		@(posedge clk) key_left <= 1'b0;
		settle(1);
		check_status(status, expected_status(1'b1, 1'b1, 4'd0, 4'd1, LIFE_INIT - 4'd1));
		press_start();
		finish_test("good hits", e);
	endtask

	task automatic test_bad_obstacle();
		int e;
		e = errors;
		run_ticks(BAD1_TICK);
		settle(0);
		check_status(status, expected_status(1'b0, 1'b0, 4'd0, 4'd1, LIFE_INIT - 4'd1));
		checks++;
		if (dut_i.obstacles[1].visible !== 1'b0) begin
			errors++;
			$display("Mismatch at %0t: obstacles[1].visible got %b, expected 0", $time,
				dut_i.obstacles[1].visible);
		end
		finish_test("bad obstacle", e);
	endtask

	task automatic test_game_over();
		int e;
		int p;
		e = errors;
		run_ticks(BOTTOM_L1 - BAD1_TICK);	// rest of the level 1 drop
		settle(1);
		check_status(status, expected_status(1'b1, 1'b1, 4'd0, 4'd1, LIFE_INIT - 4'd2));
		press_start();
		p = pulse_count;
		run_ticks(BOTTOM_L1);	// last life
		settle(1);
		check_status(status, expected_status(1'b1, 1'b1, 4'd0, 4'd0, LIFE_INIT));
		check_counter(4'(pulse_count - p), 4'd1, "reset_level_pulse count");
		press_start();
		check_status(status, expected_status(1'b0, 1'b0, 4'd0, 4'd0, LIFE_INIT));
		finish_test("game over", e);
	endtask

	initial begin
		resetN = 1'b0;
		tick = 1'b0;
		key_start = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		repeat (4) @(posedge clk);
		resetN <= 1'b1;

		test_reset();
		test_start();
		test_bottom();
		test_good_hits();
		test_bad_obstacle();
		test_game_over();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
